/* src.f */
+incdir+include
src/wb_pkg.sv
src/store_queue.sv
src/store_bus_engine.sv
src/store_retire.sv
src/write_buffer_top.sv
bench/write_buffer_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the write buffer testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 -f src.f --top-module write_buffer_tb -o sim_wb

# the log decides the result, tee keeps the pipeline status clean
./obj_dir/sim_wb | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
	echo "simulation ended without a result, see sim.log"
	exit 1
fi

/* bench/write_buffer_tb.sv */
// testbench for the store write buffer, runs the stimulus table against a bus memory model
`timescale 1ns/1ps
`include "wb_macros.svh"

module write_buffer_tb import wb_pkg::*; ();

	// one store as a requester posts it
	typedef struct packed {
		logic   v;
		tag_t   tag;
		addr_t  adr;
		ssel_t  sel;
		sdata_t dat;
	} st_t;

	localparam int N_ROWS      = 12;
	localparam int TIMEOUT_CYC = 8 + N_ROWS * 40;

	logic   clk_i;
	logic   rst_i;
	logic   p0_wr_i;
	tag_t   p0_tag_i;
	addr_t  p0_adr_i;
	ssel_t  p0_sel_i;
	sdata_t p0_dat_i;
	logic   p0_ack_o;
	addr_t  p0_ld_adr_i;
	logic   p0_hit_o;
	logic   p1_wr_i;
	tag_t   p1_tag_i;
	addr_t  p1_adr_i;
	ssel_t  p1_sel_i;
	sdata_t p1_dat_i;
	logic   p1_ack_o;
	addr_t  p1_ld_adr_i;
	logic   p1_hit_o;
	logic   bus_busy_i;
	logic   cyc_o;
	logic   stb_o;
	logic   we_o;
	bsel_t  sel_o;
	addr_t  adr_o;
	bdata_t dat_o;
	logic   ack_i;
	logic   err_i;
	logic   update_o;
	tag_t   uid_o;
	fault_t fault_o;

	// stimulus table, one row per strobe cycle
	st_t tbl_s0 [N_ROWS];
	st_t tbl_s1 [N_ROWS];
	int  tbl_busy [N_ROWS];
	bit  tbl_drain [N_ROWS];
	bit  tbl_err [N_ROWS];

	// reference state kept by the stimulus process
	st_t        ref_q [$];
	logic [7:0] ref_mem [256];
	bit         en_ref = 1'b1;
	bit         fault_seen = 1'b0;
	logic       pend_ack0 = 1'b0;
	logic       pend_ack1 = 1'b0;
	addr_t      last_adr = 32'h100;
	int         log_rd = 0;
	int         err_at = -1;

	// state owned by the bus model
	logic [7:0] mem [256];
	int         beat_log [$];
	int         beat_total = 0;
	bit         locked = 1'b0;

	write_buffer_top u_write_buffer_top (.*);

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	initial begin : watchdog
		#(TIMEOUT_CYC * 20);
		$display("run timed out after %0d cycles without reaching the end", TIMEOUT_CYC);
		$display("SIMULATION FAILED");
		$fatal(1, "timeout");
	end

	// ==================================================
	// helpers
	// ==================================================

	task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("** Error at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic st_t make_store(input tag_t tag, input addr_t adr, input ssel_t sel,
			input sdata_t dat);
		st_t s;
		s.v = 1'b1;
		s.tag = tag;
		s.adr = adr;
		s.sel = sel;
		s.dat = dat;
		return s;
	endfunction

	task automatic set_row(input int r, input st_t s0, input st_t s1, input int busy,
			input bit drain, input bit err);
		tbl_s0[r] = s0;
		tbl_s1[r] = s1;
		tbl_busy[r] = busy;
		tbl_drain[r] = drain;
		tbl_err[r] = err;
	endtask

	// a store needs a second beat when a selected byte lies beyond the end of its 16-byte line
	function automatic int beats_needed(input st_t s);
		int n;
		n = 1;
		for (int b = 0; b < 8; b++) begin
			if (s.sel[b] && (int'(s.adr[3:0]) + b > 15)) begin
				n = 2;
			end
		end
		return n;
	endfunction

	function automatic logic line_pending(input addr_t a);
		logic hit;
		hit = 1'b0;
		foreach (ref_q[i]) begin
			if (ref_q[i].adr[31:4] == a[31:4]) begin
				hit = 1'b1;
			end
		end
		return hit;
	endfunction

	// one completion pulse, checked against the oldest reference entry
	task automatic retire_store();
		st_t head;
		int  nb;
		int  b;
		compare(32'(ref_q.size() != 0), 32'd1, "completion with no store pending");
		compare(32'(beat_log.size() > log_rd), 32'd1, "completion without a bus cycle");
		head = ref_q.pop_front();
		nb = beat_log[log_rd];
		log_rd++;
		compare(32'(uid_o), 32'(head.tag), "completion tag order");
		if (locked && !fault_seen) begin
			// the flush drops the rest and cancels acks of the flush edge
			compare(32'(fault_o), 32'(FAULT_BUS), "fault code on bus error");
			fault_seen = 1'b1;
			en_ref = 1'b0;
			pend_ack0 = 1'b0;
			pend_ack1 = 1'b0;
			ref_q.delete();
		end else begin
			compare(32'(fault_o), 32'(FAULT_NONE), "fault code on completion");
			compare(32'(nb), 32'(beats_needed(head)), "beats in one bus cycle");
			for (b = 0; b < 8; b++) begin
				if (head.sel[b]) begin
					ref_mem[head.adr[7:0] + 8'(b)] = head.dat[8*b +: 8];
				end
			end
		end
	endtask

	// one clock cycle of stimulus, with the checks of the edge just passed
	task automatic run_cycle(input st_t s0, input st_t s1, input logic busy);
		logic hit0;
		logic hit1;
		logic take0;
		logic take1;
		@(posedge clk_i);
		#2;
		if (update_o) begin
			retire_store();
		end
		compare(32'(p0_ack_o), 32'(pend_ack0), "port 0 store ack");
		compare(32'(p1_ack_o), 32'(pend_ack1), "port 1 store ack");
		p0_wr_i = s0.v;
		p0_tag_i = s0.tag;
		p0_adr_i = s0.adr;
		p0_sel_i = s0.sel;
		p0_dat_i = s0.dat;
		p1_wr_i = s1.v;
		p1_tag_i = s1.tag;
		p1_adr_i = s1.adr;
		p1_sel_i = s1.sel;
		p1_dat_i = s1.dat;
		bus_busy_i = busy;
		// port 0 loads near the newest store, port 1 anywhere including unused lines
		p0_ld_adr_i = last_adr ^ ($urandom % 32'd16);
		p1_ld_adr_i = 32'h100 + ($urandom % 32'd384);
		hit0 = line_pending(p0_ld_adr_i);
		hit1 = line_pending(p1_ld_adr_i);
		// free slots are counted before any pop at the coming edge
		take0 = en_ref & s0.v & (ref_q.size() < `WB_DEPTH);
		take1 = en_ref & s1.v &
			(s0.v ? (ref_q.size() < `WB_DEPTH - 1) : (ref_q.size() < `WB_DEPTH));
		if (take0) begin
			ref_q.push_back(s0);
			last_adr = s0.adr;
		end
		if (take1) begin
			ref_q.push_back(s1);
			last_adr = s1.adr;
		end
		pend_ack0 = take0;
		pend_ack1 = take1;
		#1;
		compare(32'(p0_hit_o), 32'(hit0), "port 0 load hit");
		compare(32'(p1_hit_o), 32'(hit1), "port 1 load hit");
	endtask

	// ==================================================
	// bus memory model
	// ==================================================

	initial begin : bus_model
		int wait_n;
		bit counting;
		bit in_cyc;
		int beats;
		int l;
		ack_i = 1'b0;
		err_i = 1'b0;
		counting = 1'b0;
		in_cyc = 1'b0;
		beats = 0;
		wait_n = 0;
		for (l = 0; l < 256; l++) begin
			mem[l] = 8'(l * 7 + 3);
		end
		forever begin
			@(posedge clk_i);
			#2;
			compare(32'(locked & stb_o), 32'd0, "bus strobe after a bus error");
			// beats are counted per cycle so a split store must keep cyc high
			if (cyc_o && !in_cyc) begin
				in_cyc = 1'b1;
				beats = 0;
			end else if (!cyc_o && in_cyc) begin
				beat_log.push_back(beats);
				in_cyc = 1'b0;
			end
			if (ack_i || err_i) begin
				ack_i = 1'b0;
				err_i = 1'b0;
			end else if (stb_o) begin
				if (!counting) begin
					counting = 1'b1;
					wait_n = $urandom % 4;
				end
				if (wait_n == 0) begin
					counting = 1'b0;
					beats++;
					compare(32'(we_o), 32'd1, "write enable during a beat");
					if (beat_total == err_at) begin
						err_i = 1'b1;
						locked = 1'b1;
					end else begin
						ack_i = 1'b1;
						for (l = 0; l < 16; l++) begin
							if (sel_o[l]) begin
								mem[{adr_o[7:4], 4'(l)}] = dat_o[8*l +: 8];
							end
						end
					end
					beat_total++;
				end else begin
					wait_n--;
				end
			end
		end
	end

	// ==================================================
	// stimulus
	// ==================================================

	initial begin : stimulus
		st_t none;
		int  r;
		int  k;
		int  i;
		void'($urandom(28182));
		none = '0;
		rst_i = 1'b1;
		p0_wr_i = 1'b0;
		p0_tag_i = '0;
		p0_adr_i = '0;
		p0_sel_i = '0;
		p0_dat_i = '0;
		p1_wr_i = 1'b0;
		p1_tag_i = '0;
		p1_adr_i = '0;
		p1_sel_i = '0;
		p1_dat_i = '0;
		p0_ld_adr_i = '0;
		p1_ld_adr_i = '0;
		bus_busy_i = 1'b0;
		for (i = 0; i < 256; i++) begin
			ref_mem[i] = 8'(i * 7 + 3);
		end

		// plain and line-crossing stores, each group drained before the next
		set_row(0, make_store(4'h1, 32'h100, 8'hff, 64'h1122_3344_5566_7788),
			make_store(4'h2, 32'h110, 8'h0f, 64'h99aa_bbcc_ddee_f001), 0, 1'b0, 1'b0);
		set_row(1, make_store(4'h3, 32'h11c, 8'hff, 64'ha1a2_a3a4_a5a6_a7a8),
			none, 0, 1'b1, 1'b0);
		set_row(2, none,
			make_store(4'h4, 32'h13a, 8'hc3, 64'hb1b2_b3b4_b5b6_b7b8), 0, 1'b0, 1'b0);
		set_row(3, make_store(4'h5, 32'h148, 8'h3c, 64'hc1c2_c3c4_c5c6_c7c8),
			make_store(4'h6, 32'h14f, 8'h01, 64'h0000_0000_0000_00d9), 0, 1'b1, 1'b0);
		// bus held busy so the queue fills, the last slot goes to port 0 only
		set_row(4, make_store(4'h7, 32'h160, 8'hff, 64'h0102_0304_0506_0708),
			make_store(4'h8, 32'h170, 8'hff, 64'h1112_1314_1516_1718), 1, 1'b0, 1'b0);
		set_row(5, make_store(4'h9, 32'h180, 8'h0f, 64'h2122_2324_2526_2728),
			make_store(4'ha, 32'h184, 8'hf0, 64'h3132_3334_3536_3738), 1, 1'b0, 1'b0);
		set_row(6, make_store(4'hb, 32'h190, 8'hff, 64'h4142_4344_4546_4748),
			none, 1, 1'b0, 1'b0);
		set_row(7, make_store(4'hc, 32'h1a0, 8'hff, 64'h5152_5354_5556_5758),
			make_store(4'hd, 32'h1b0, 8'hff, 64'h6162_6364_6566_6768), 1, 1'b0, 1'b0);
		set_row(8, make_store(4'he, 32'h1c0, 8'hff, 64'h7172_7374_7576_7778),
			make_store(4'hf, 32'h1d0, 8'hff, 64'h8182_8384_8586_8788), 3, 1'b1, 1'b0);
		// first beat of this row answers with an error, the buffer locks up
		set_row(9, make_store(4'h1, 32'h1e0, 8'h0f, 64'h9192_9394_9596_9798),
			make_store(4'h2, 32'h1e8, 8'hff, 64'ha9aa_abac_adae_afa0), 0, 1'b1, 1'b1);
		set_row(10, make_store(4'h3, 32'h100, 8'hff, 64'hdead_beef_dead_beef),
			make_store(4'h4, 32'h110, 8'hff, 64'hfeed_face_feed_face), 0, 1'b0, 1'b0);
		set_row(11, none,
			make_store(4'h5, 32'h120, 8'hff, 64'h0bad_0bad_0bad_0bad), 0, 1'b0, 1'b0);

		repeat (8) @(posedge clk_i);
		#2;
		rst_i = 1'b0;
		compare(32'({cyc_o, stb_o, we_o, p0_ack_o, p1_ack_o, update_o}), 32'd0,
			"bus strobes and pulses after reset");
		compare(32'(sel_o), 32'd0, "lane select after reset");
		compare(32'(fault_o), 32'(FAULT_NONE), "fault code after reset");

		for (r = 0; r < N_ROWS; r++) begin
			if (tbl_err[r]) begin
				err_at = beat_total;
			end
			run_cycle(tbl_s0[r], tbl_s1[r], tbl_busy[r] != 0);
			for (k = 1; k < tbl_busy[r]; k++) begin
				run_cycle(none, none, 1'b1);
			end
			if (tbl_drain[r]) begin
				while (ref_q.size() != 0) begin
					run_cycle(none, none, 1'b0);
				end
			end
		end
		repeat (10) run_cycle(none, none, 1'b0);

		compare(32'(ref_q.size()), 32'd0, "stores left pending at the end");
		compare(32'(beat_log.size()), 32'(log_rd), "bus cycles without a completion");
		for (i = 0; i < 256; i++) begin
			compare(32'(mem[i]), 32'(ref_mem[i]), $sformatf("memory byte at index %0h", i));
		end
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

/* src/write_buffer_top.sv */
// top level of the store write buffer, connecting queue, bus engine and retire unit
`timescale 1ns/1ps

module write_buffer_top import wb_pkg::*; (
	input  logic   clk_i,
	input  logic   rst_i,
	input  logic   p0_wr_i,
	input  tag_t   p0_tag_i,
	input  addr_t  p0_adr_i,
	input  ssel_t  p0_sel_i,
	input  sdata_t p0_dat_i,
	output logic   p0_ack_o,
	input  addr_t  p0_ld_adr_i,
	output logic   p0_hit_o,
	input  logic   p1_wr_i,
	input  tag_t   p1_tag_i,
	input  addr_t  p1_adr_i,
	input  ssel_t  p1_sel_i,
	input  sdata_t p1_dat_i,
	output logic   p1_ack_o,
	input  addr_t  p1_ld_adr_i,
	output logic   p1_hit_o,
	input  logic   bus_busy_i,
	output logic   cyc_o,
	output logic   stb_o,
	output logic   we_o,
	output bsel_t  sel_o,
	output addr_t  adr_o,
	output bdata_t dat_o,
	input  logic   ack_i,
	input  logic   err_i,
	output logic   update_o,
	output tag_t   uid_o,
	output fault_t fault_o
);

	// head of the queue, seen by the engine and the retire unit
	logic   head_valid;
	tag_t   head_tag;
	addr_t  head_adr;
	ssel_t  head_sel;
	sdata_t head_dat;

	// end-of-cycle strobes and the commands they turn into
	logic   eng_done;
	logic   eng_err;
	logic   pop;
	logic   flush;

	store_queue u_store_queue (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.p0_wr_i      (p0_wr_i),
		.p0_tag_i     (p0_tag_i),
		.p0_adr_i     (p0_adr_i),
		.p0_sel_i     (p0_sel_i),
		.p0_dat_i     (p0_dat_i),
		.p1_wr_i      (p1_wr_i),
		.p1_tag_i     (p1_tag_i),
		.p1_adr_i     (p1_adr_i),
		.p1_sel_i     (p1_sel_i),
		.p1_dat_i     (p1_dat_i),
		.p0_ld_adr_i  (p0_ld_adr_i),
		.p1_ld_adr_i  (p1_ld_adr_i),
		.pop_i        (pop),
		.flush_i      (flush),
		.p0_ack_o     (p0_ack_o),
		.p1_ack_o     (p1_ack_o),
		.p0_hit_o     (p0_hit_o),
		.p1_hit_o     (p1_hit_o),
		.head_valid_o (head_valid),
		.head_tag_o   (head_tag),
		.head_adr_o   (head_adr),
		.head_sel_o   (head_sel),
		.head_dat_o   (head_dat)
	);

	store_bus_engine u_store_bus_engine (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.head_valid_i (head_valid),
		.head_adr_i   (head_adr),
		.head_sel_i   (head_sel),
		.head_dat_i   (head_dat),
		.bus_busy_i   (bus_busy_i),
		.ack_i        (ack_i),
		.err_i        (err_i),
		.cyc_o        (cyc_o),
		.stb_o        (stb_o),
		.we_o         (we_o),
		.sel_o        (sel_o),
		.adr_o        (adr_o),
		.dat_o        (dat_o),
		.done_o       (eng_done),
		.err_o        (eng_err)
	);

	store_retire u_store_retire (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.done_i     (eng_done),
		.err_i      (eng_err),
		.head_tag_i (head_tag),
		.pop_o      (pop),
		.flush_o    (flush),
		.update_o   (update_o),
		.uid_o      (uid_o),
		.fault_o    (fault_o)
	);

endmodule

/* src/store_retire.sv */
// turns the engine's end-of-cycle strobes into the completion pulse, fault code, pop and flush
`timescale 1ns/1ps

module store_retire import wb_pkg::*; (
	input  logic   clk_i,
	input  logic   rst_i,
	input  logic   done_i,
	input  logic   err_i,
	input  tag_t   head_tag_i,
	output logic   pop_o,
	output logic   flush_o,
	output logic   update_o,
	output tag_t   uid_o,
	output fault_t fault_o
);

	logic finish;

	// the store ends one way or the other, and its tag is reported either way
	assign finish = done_i | err_i;

	// ==================================================
	// queue commands
	// ==================================================

	// the head leaves on the same edge as the completion pulse rises
	assign pop_o   = done_i & ~err_i;
	// after an error the whole queue goes, not just the head
	assign flush_o = err_i;

	// ==================================================
	// completion report
	// ==================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			update_o <= 1'b0;
			fault_o  <= FAULT_NONE;
		end else begin
			update_o <= finish;
			// the fault stays reported until the next reset
			if (err_i) begin
				fault_o <= FAULT_BUS;
			end
		end
	end

	// head tag is still the finished store while the strobe is high
	always_ff @(posedge clk_i) begin
		if (finish) begin
			uid_o <= head_tag_i;
		end
	end

endmodule

/* src/store_bus_engine.sv */
// bus master that writes the head store as one or two lane-aligned beats in one bus cycle
`timescale 1ns/1ps
`include "wb_macros.svh"

module store_bus_engine import wb_pkg::*; (
	input  logic   clk_i,
	input  logic   rst_i,
	input  logic   head_valid_i,
	input  addr_t  head_adr_i,
	input  ssel_t  head_sel_i,
	input  sdata_t head_dat_i,
	input  logic   bus_busy_i,
	input  logic   ack_i,
	input  logic   err_i,
	output logic   cyc_o,
	output logic   stb_o,
	output logic   we_o,
	output bsel_t  sel_o,
	output addr_t  adr_o,
	output bdata_t dat_o,
	output logic   done_o,
	output logic   err_o
);

	// a store can spill up to one select width past the end of the line
	localparam int MASK_W  = `WB_BSEL_W + `WB_SEL_W;
	localparam int SHIFT_W = `WB_BUS_W + `WB_DATA_W;
	localparam int LINE_W  = `WB_ADDR_W - `WB_LINE_LSB;

	eng_state_t state;

	logic [`WB_LINE_LSB-1:0] lane_off;
	logic [MASK_W-1:0]       lane_mask;
	logic [SHIFT_W-1:0]      lane_dat;
	logic                    needs_beat2;
	addr_t                   next_line;

	// the head stays put until the retire unit pops it, so lanes come straight from it
	always_comb begin
		lane_off    = head_adr_i[`WB_LINE_LSB-1:0];
		lane_mask   = MASK_W'(head_sel_i) << lane_off;
		lane_dat    = SHIFT_W'(head_dat_i) << {lane_off, 3'b000};
		needs_beat2 = |lane_mask[MASK_W-1:`WB_BSEL_W];
		next_line   = {head_adr_i[`WB_ADDR_W-1:`WB_LINE_LSB] + LINE_W'(1),
			{`WB_LINE_LSB{1'b0}}};
	end

	// ==================================================
	// bus cycle sequencing
	// ==================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state  <= ENG_IDLE;
			cyc_o  <= 1'b0;
			stb_o  <= 1'b0;
			we_o   <= 1'b0;
			sel_o  <= '0;
			done_o <= 1'b0;
			err_o  <= 1'b0;
		end else begin
			done_o <= 1'b0;
			err_o  <= 1'b0;
			case (state)
			ENG_IDLE: begin
				// hold off while the last store's end is still being retired
				if (head_valid_i && !bus_busy_i && !ack_i && !done_o && !err_o) begin
					cyc_o <= 1'b1;
					stb_o <= 1'b1;
					we_o  <= 1'b1;
					sel_o <= lane_mask[`WB_BSEL_W-1:0];
					adr_o <= head_adr_i;
					dat_o <= lane_dat[`WB_BUS_W-1:0];
					state <= ENG_ACK1;
				end
			end
			ENG_ACK1: begin
				if (ack_i || err_i) begin
					stb_o <= 1'b0;
					if (err_i || !needs_beat2) begin
						// an error here skips beat 2 altogether
						cyc_o  <= 1'b0;
						we_o   <= 1'b0;
						sel_o  <= '0;
						done_o <= ~err_i;
						err_o  <= err_i;
						state  <= ENG_IDLE;
					end else begin
						// spilled bytes go to the start of the next line
						sel_o <= bsel_t'(lane_mask[MASK_W-1:`WB_BSEL_W]);
						adr_o <= next_line;
						dat_o <= bdata_t'(lane_dat[SHIFT_W-1:`WB_BUS_W]);
						state <= ENG_BEAT2;
					end
				end
			end
			ENG_BEAT2: begin
				// cyc stays high, only the strobe drops between the beats
				if (!ack_i) begin
					stb_o <= 1'b1;
					state <= ENG_ACK2;
				end
			end
			ENG_ACK2: begin
				if (ack_i || err_i) begin
					cyc_o  <= 1'b0;
					stb_o  <= 1'b0;
					we_o   <= 1'b0;
					sel_o  <= '0;
					done_o <= ~err_i;
					err_o  <= err_i;
					state  <= ENG_IDLE;
				end
			end
			default: begin
				state <= ENG_IDLE;
			end
			endcase
		end
	end

endmodule

/* src/store_queue.sv */
// ordered queue of pending stores with two insert ports, head pop, flush and load-hit compare
`timescale 1ns/1ps
`include "wb_macros.svh"

module store_queue import wb_pkg::*; (
	input  logic   clk_i,
	input  logic   rst_i,
	input  logic   p0_wr_i,
	input  tag_t   p0_tag_i,
	input  addr_t  p0_adr_i,
	input  ssel_t  p0_sel_i,
	input  sdata_t p0_dat_i,
	input  logic   p1_wr_i,
	input  tag_t   p1_tag_i,
	input  addr_t  p1_adr_i,
	input  ssel_t  p1_sel_i,
	input  sdata_t p1_dat_i,
	input  addr_t  p0_ld_adr_i,
	input  addr_t  p1_ld_adr_i,
	input  logic   pop_i,
	input  logic   flush_i,
	output logic   p0_ack_o,
	output logic   p1_ack_o,
	output logic   p0_hit_o,
	output logic   p1_hit_o,
	output logic   head_valid_o,
	output tag_t   head_tag_o,
	output addr_t  head_adr_o,
	output ssel_t  head_sel_o,
	output sdata_t head_dat_o
);

	localparam int DEPTH = `WB_DEPTH;
	localparam int CNT_W = $clog2(DEPTH + 1);

	// entry 0 is always the oldest store, entries fill upward from there
	logic [DEPTH-1:0] q_valid;
	tag_t   q_tag [DEPTH];
	addr_t  q_adr [DEPTH];
	ssel_t  q_sel [DEPTH];
	sdata_t q_dat [DEPTH];

	logic [CNT_W-1:0] fill;
	logic             wb_en;

	logic             pop_eff;
	logic             room1;
	logic             room2;
	logic             take0;
	logic             take1;
	logic [CNT_W-1:0] slot0;
	logic [CNT_W-1:0] slot1;
	logic [CNT_W-1:0] fill_nxt;

	// ==================================================
	// insertion rule
	// ==================================================

	always_comb begin
		pop_eff = pop_i & q_valid[0];
		// free space is judged on the fill before any pop in this cycle
		room1 = fill < CNT_W'(DEPTH);
		room2 = fill < CNT_W'(DEPTH - 1);
		take0 = wb_en & ~flush_i & p0_wr_i & room1;
		// with both strobes port 1 needs a second slot behind port 0
		take1 = wb_en & ~flush_i & p1_wr_i & (p0_wr_i ? room2 : room1);
		// a pop shifts the queue down, so new entries land one place lower
		slot0 = fill - CNT_W'(pop_eff);
		slot1 = slot0 + CNT_W'(take0);
		fill_nxt = slot1 + CNT_W'(take1);
	end

	// valid bits, fill count, enable latch and the store acks
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			q_valid  <= '0;
			fill     <= '0;
			wb_en    <= 1'b1;
			p0_ack_o <= 1'b0;
			p1_ack_o <= 1'b0;
		end else begin
			p0_ack_o <= take0;
			p1_ack_o <= take1;
			if (flush_i) begin
				// a bus error drops everything and locks the buffer until reset
				q_valid <= '0;
				fill    <= '0;
				wb_en   <= 1'b0;
			end else begin
				if (pop_eff) begin
					q_valid <= q_valid >> 1;
				end
				if (take0) begin
					q_valid[slot0] <= 1'b1;
				end
				if (take1) begin
					q_valid[slot1] <= 1'b1;
				end
				fill <= fill_nxt;
			end
		end
	end

	// store payload, shifted along with the valid bits
	always_ff @(posedge clk_i) begin
		if (pop_eff) begin
			for (int i = 0; i < DEPTH - 1; i++) begin
				q_tag[i] <= q_tag[i+1];
				q_adr[i] <= q_adr[i+1];
				q_sel[i] <= q_sel[i+1];
				q_dat[i] <= q_dat[i+1];
			end
		end
		if (take0) begin
			q_tag[slot0] <= p0_tag_i;
			q_adr[slot0] <= p0_adr_i;
			q_sel[slot0] <= p0_sel_i;
			q_dat[slot0] <= p0_dat_i;
		end
		if (take1) begin
			q_tag[slot1] <= p1_tag_i;
			q_adr[slot1] <= p1_adr_i;
			q_sel[slot1] <= p1_sel_i;
			q_dat[slot1] <= p1_dat_i;
		end
	end

	// ==================================================
	// load hit compare on the 16-byte line
	// ==================================================

	always_comb begin
		p0_hit_o = 1'b0;
		p1_hit_o = 1'b0;
		for (int i = 0; i < DEPTH; i++) begin
			if (q_valid[i] && q_adr[i][`WB_ADDR_W-1:`WB_LINE_LSB] ==
					p0_ld_adr_i[`WB_ADDR_W-1:`WB_LINE_LSB]) begin
				p0_hit_o = 1'b1;
			end
			if (q_valid[i] && q_adr[i][`WB_ADDR_W-1:`WB_LINE_LSB] ==
					p1_ld_adr_i[`WB_ADDR_W-1:`WB_LINE_LSB]) begin
				p1_hit_o = 1'b1;
			end
		end
	end

	// the head entry feeds the bus engine and the retire unit
	assign head_valid_o = q_valid[0];
	assign head_tag_o   = q_tag[0];
	assign head_adr_o   = q_adr[0];
	assign head_sel_o   = q_sel[0];
	assign head_dat_o   = q_dat[0];

endmodule

/* src/wb_pkg.sv */
// shared types of the store write buffer, wildcard-imported by every RTL module
`include "wb_macros.svh"

package wb_pkg;

	// ==================================================
	// store and bus vectors
	// ==================================================

	typedef logic [`WB_ADDR_W-1:0] addr_t;
	typedef logic [`WB_DATA_W-1:0] sdata_t;
	typedef logic [`WB_SEL_W-1:0]  ssel_t;
	typedef logic [`WB_BUS_W-1:0]  bdata_t;
	typedef logic [`WB_BSEL_W-1:0] bsel_t;
	typedef logic [`WB_TAG_W-1:0]  tag_t;

	// fault code reported with the completion, sticky until reset
	typedef logic [1:0] fault_t;
	localparam fault_t FAULT_NONE = 2'd0;
	localparam fault_t FAULT_BUS  = 2'd1;

	// ==================================================
	// bus engine states
	// ==================================================

	// beat 1 is raised from idle, beat 2 only for line-crossing stores
	typedef enum logic [1:0] {
		ENG_IDLE  = 2'd0,
		ENG_ACK1  = 2'd1,
		ENG_BEAT2 = 2'd2,
		ENG_ACK2  = 2'd3
	} eng_state_t;

endpackage

/* include/wb_macros.svh */
// sizes of the store write buffer, included by the package, the RTL and the testbench
`ifndef WB_MACROS_SVH
`define WB_MACROS_SVH

// number of pending stores the buffer can hold
`define WB_DEPTH 6

// store side: byte address, store data and one select bit per data byte
`define WB_ADDR_W 32
`define WB_DATA_W 64
`define WB_SEL_W (`WB_DATA_W / 8)

// bus side: one 16-byte line per beat, one lane select bit per byte
`define WB_BUS_W 128
`define WB_BSEL_W (`WB_BUS_W / 8)
`define WB_LINE_LSB 4

// tag of the issuing instruction, returned on completion
`define WB_TAG_W 4

`endif
